// File: lsu_top.f
+incdir+src
src/lsu_pkg.sv
src/lsu_req.sv
src/lsu_dcache.sv
src/lsu_axil_master.sv
src/lsu_load_ext.sv
src/lsu_top.sv
test/lsu_assert.sv
test/lsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= lsu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
  import lsu_pkg::*;

  localparam int unsigned CLK_PERIOD   = 10;
  localparam int unsigned RESET_CYCLES = 8;
  localparam int unsigned NUM_OPS      = 600;
  // worst case per op with ready delays up to 3
  localparam int unsigned OP_CYCLES    = 24;
  localparam logic [31:0] LFSR_SEED    = 32'd71416;
  localparam addr_t       WIN_BASE     = 32'h0000_4000;

  logic    clk;
  logic    arst_n_i;
  logic    req_valid_i;
  logic    req_ready_o;
  lsu_op_e req_op_i;
  addr_t   req_addr_i;
  data_t   req_wdata_i;
  logic    resp_valid_o;
  data_t   resp_rdata_o;
  logic    resp_err_o;
  addr_t   m_araddr_o;
  logic    m_arvalid_o;
  logic    m_arready_i;
  data_t   m_rdata_i;
  resp_t   m_rresp_i;
  logic    m_rvalid_i;
  logic    m_rready_o;
  addr_t   m_awaddr_o;
  logic    m_awvalid_o;
  logic    m_awready_i;
  data_t   m_wdata_o;
  strb_t   m_wstrb_o;
  logic    m_wvalid_o;
  logic    m_wready_i;
  resp_t   m_bresp_i;
  logic    m_bvalid_i;
  logic    m_bready_o;

  // slave memory, also the reference for loads
  data_t       mem [256];
  logic [31:0] lfsr_q;
  int unsigned ar_count;
  int unsigned aw_count;
  logic        bus_err;
  strb_t       seen_strb;
  data_t       seen_wdata;
  logic        line_valid [64];
  tag_t        line_tag [64];

  lsu_top UUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic report_error(input string what);
    $display("%s", what);
    abort_run();
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    abort_run();
  endtask

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    int unsigned i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic data_t fill_word(input addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  // 4 tags over 4 lines, so refills conflict often
  function automatic addr_t pick_addr();
    addr_t       a;
    logic [31:0] r;
    r = rand_bits(6);
    a = WIN_BASE;
    a[9:8] = r[1:0];
    a[3:2] = r[3:2];
    a[1:0] = r[5:4];
    return a;
  endfunction

  function automatic logic misaligned(input lsu_op_e op, input logic [1:0] off);
    case (op)
      LH, LHU, SH: return off[0];
      LW, SW:      return off != 2'b00;
      default:     return 1'b0;
    endcase
  endfunction

  function automatic strb_t store_strb(input lsu_op_e op, input logic [1:0] off);
    case (op)
      SB:      return 4'b0001 << off;
      SH:      return 4'b0011 << off;
      SW:      return 4'b1111;
      default: return 4'b0000;
    endcase
  endfunction

  function automatic data_t lane_mask(input strb_t s);
    data_t       m;
    int unsigned b;
    for (b = 0; b < 4; b++)
      m[8*b +: 8] = {8{s[b]}};
    return m;
  endfunction

  function automatic data_t expect_load(input lsu_op_e op, input data_t w, input logic [1:0] off);
    data_t s;
    s = w >> (8 * off);
    case (op)
      LB:      return {{24{s[7]}}, s[7:0]};
      LBU:     return {24'h0, s[7:0]};
      LH:      return {{16{s[15]}}, s[15:0]};
      LHU:     return {16'h0, s[15:0]};
      LW:      return w;
      default: return '0;
    endcase
  endfunction

  task automatic serve_read();
    logic [31:0] r;
    logic [7:0]  widx;
    logic        err;
    r = rand_bits(7);
    repeat (r[1:0]) @(negedge clk);
    assert (m_araddr_o[1:0] == 2'b00 && m_araddr_o[31:10] == WIN_BASE[31:10])
    else report_error("AR address outside the window or not word-aligned");
    widx = m_araddr_o[9:2];
    m_arready_i = 1'b1;
    @(negedge clk);
    m_arready_i = 1'b0;
    ar_count++;
    err = (r[6:4] == 3'b000);
    repeat (r[3:2]) @(negedge clk);
    m_rvalid_i = 1'b1;
    m_rresp_i  = err ? 2'b10 : 2'b00;
    m_rdata_i  = err ? 32'hdead_beef : mem[widx];
    bus_err    = err;
    @(negedge clk);
    m_rvalid_i = 1'b0;
  endtask

  task automatic serve_write();
    logic [31:0] r;
    logic [1:0]  aw_dly;
    logic [1:0]  w_dly;
    logic        aw_done;
    logic        w_done;
    logic [7:0]  widx;
    logic        err;
    int unsigned b;
    r = rand_bits(9);
    aw_dly = r[1:0];
    w_dly = r[3:2];
    aw_done = 1'b0;
    w_done = 1'b0;
    widx = '0;
    // aw and w accepted on their own delays
    while (!(aw_done && w_done))
    begin
      if (m_awready_i)
      begin
        m_awready_i = 1'b0;
        aw_done = 1'b1;
      end
      else if (!aw_done && aw_dly == 0)
      begin
        assert (m_awaddr_o[1:0] == 2'b00 && m_awaddr_o[31:10] == WIN_BASE[31:10])
        else report_error("AW address outside the window or not word-aligned");
        widx = m_awaddr_o[9:2];
        m_awready_i = 1'b1;
      end
      else if (!aw_done)
        aw_dly = aw_dly - 1'b1;
      if (m_wready_i)
      begin
        m_wready_i = 1'b0;
        w_done = 1'b1;
      end
      else if (!w_done && w_dly == 0)
      begin
        seen_strb = m_wstrb_o;
        seen_wdata = m_wdata_o;
        m_wready_i = 1'b1;
      end
      else if (!w_done)
        w_dly = w_dly - 1'b1;
      if (!(aw_done && w_done))
        @(negedge clk);
    end
    err = (r[8:6] == 3'b000);
    repeat (r[5:4]) @(negedge clk);
    if (!err)
      for (b = 0; b < 4; b++)
        if (seen_strb[b])
          mem[widx][8*b +: 8] = seen_wdata[8*b +: 8];
    aw_count++;
    bus_err = err;
    m_bvalid_i = 1'b1;
    m_bresp_i = err ? 2'b10 : 2'b00;
    @(negedge clk);
    m_bvalid_i = 1'b0;
  endtask

  always
  begin
    @(negedge clk);
    if (m_arvalid_o)
      serve_read();
    else if (m_awvalid_o || m_wvalid_o)
      serve_write();
  end

  task automatic do_op(input lsu_op_e op, input addr_t addr, input data_t wdata);
    int unsigned lat;
    int unsigned ar_before;
    int unsigned aw_before;
    logic [1:0]  off;
    logic        load;
    logic        mis;
    logic        hit;
    index_t      idx;
    tag_t        tag;
    logic        exp_err;
    data_t       exp_data;
    strb_t       exp_strb;
    off = addr[1:0];
    idx = addr[7:2];
    tag = addr[31:8];
    load = op inside {LB, LBU, LH, LHU, LW};
    mis = misaligned(op, off);
    hit = line_valid[idx] && line_tag[idx] == tag;
    ar_before = ar_count;
    aw_before = aw_count;
    bus_err = 1'b0;
    req_valid_i = 1'b1;
    req_op_i = op;
    req_addr_i = addr;
    req_wdata_i = wdata;
    while (!req_ready_o)
      @(negedge clk);
    @(negedge clk);
    req_valid_i = 1'b0;
    lat = 1;
    while (!resp_valid_o)
    begin
      @(negedge clk);
      lat++;
    end
    exp_err = mis || (!(load && hit) && bus_err);
    exp_data = (load && !exp_err) ? expect_load(op, mem[addr[9:2]], off) : '0;
    assert (resp_err_o == exp_err)
    else mismatch("resp_err_o", 32'(resp_err_o), 32'(exp_err));
    assert (resp_rdata_o == exp_data)
    else mismatch("resp_rdata_o", resp_rdata_o, exp_data);
    if (mis || (load && hit))
    begin
      assert (lat == 1)
      else report_error("response did not come in the cycle after acceptance");
      assert (ar_count == ar_before && aw_count == aw_before)
      else report_error("bus transaction for a request that needs no bus");
    end
    else if (load)
    begin
      assert (ar_count == ar_before + 1)
      else report_error("load miss did not issue exactly one read");
    end
    else
    begin
      exp_strb = store_strb(op, off);
      assert (aw_count == aw_before + 1)
      else report_error("store did not issue exactly one write");
      assert (seen_strb == exp_strb)
      else mismatch("m_wstrb_o", 32'(seen_strb), 32'(exp_strb));
      assert ((seen_wdata & lane_mask(exp_strb)) == ((wdata << (8 * off)) & lane_mask(exp_strb)))
      else mismatch("m_wdata_o", seen_wdata, wdata << (8 * off));
    end
    // expected cache contents after this op
    if (!mis && load && !hit && !bus_err)
    begin
      line_valid[idx] = 1'b1;
      line_tag[idx] = tag;
    end
    if (!mis && !load && hit)
      line_valid[idx] = 1'b0;
    @(negedge clk);
    assert (!resp_valid_o && req_ready_o && !m_arvalid_o && !m_awvalid_o && !m_wvalid_o)
    else report_error("response longer than one cycle, port closed, or stray bus valid");
  endtask

  always @(negedge clk)
    if (UUT.u_assert.err_count != 0)
      report_error("a protocol assertion in lsu_assert failed");

  initial
  begin
    #((NUM_OPS + 16) * OP_CYCLES * CLK_PERIOD);
    report_error("watchdog timeout, the run did not finish in time");
  end

  initial
  begin
    int unsigned i;
    logic [31:0] r;
    clk = 1'b0;
    arst_n_i = 1'b1;
    req_valid_i = 1'b0;
    req_op_i = LB;
    req_addr_i = '0;
    req_wdata_i = '0;
    m_arready_i = 1'b0;
    m_rdata_i = '0;
    m_rresp_i = '0;
    m_rvalid_i = 1'b0;
    m_awready_i = 1'b0;
    m_wready_i = 1'b0;
    m_bresp_i = '0;
    m_bvalid_i = 1'b0;
    lfsr_q = LFSR_SEED;
    ar_count = 0;
    aw_count = 0;
    bus_err = 1'b0;
    seen_strb = '0;
    seen_wdata = '0;
    for (i = 0; i < 256; i++)
      mem[i] = fill_word(WIN_BASE + (i << 2));
    for (i = 0; i < 64; i++)
    begin
      line_valid[i] = 1'b0;
      line_tag[i] = '0;
    end
    #1 arst_n_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;
    @(negedge clk);
    // refill, hit, store hit, reload, misaligned word
    do_op(LW, WIN_BASE + 32'h10, '0);
    do_op(LW, WIN_BASE + 32'h10, '0);
    do_op(SH, WIN_BASE + 32'h12, 32'h0000_8001);
    do_op(LB, WIN_BASE + 32'h13, '0);
    do_op(LW, WIN_BASE + 32'h11, '0);
    for (i = 0; i < NUM_OPS; i++)
    begin
      r = rand_bits(3);
      do_op(lsu_op_e'(r[2:0]), pick_addr(), rand_bits(32));
    end
    @(negedge clk);
    if (UUT.u_assert.err_count == 0)
    begin
      $display("All tests passed");
      $finish;
    end
    else
      report_error("a protocol assertion in lsu_assert failed");
  end

endmodule

`default_nettype wire

// File: test/lsu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_assert (
  input wire                 clk,
  input wire                 arst_n_i,
  input wire                 req_valid_i,
  input wire                 req_ready_o,
  input wire                 resp_valid_o,
  input wire lsu_pkg::addr_t m_araddr_o,
  input wire                 m_arvalid_o,
  input wire                 m_arready_i,
  input wire                 m_rready_o,
  input wire lsu_pkg::addr_t m_awaddr_o,
  input wire                 m_awvalid_o,
  input wire                 m_awready_i,
  input wire lsu_pkg::data_t m_wdata_o,
  input wire lsu_pkg::strb_t m_wstrb_o,
  input wire                 m_wvalid_o,
  input wire                 m_wready_i,
  input wire                 m_bready_o
);

  int unsigned err_count = 0;

  // valid holds with its payload until ready
  ar_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o))
  else
  begin
    err_count++;
    $error("AR valid or address changed before handshake");
  end

  aw_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
    m_awvalid_o && !m_awready_i |=> m_awvalid_o && $stable(m_awaddr_o))
  else
  begin
    err_count++;
    $error("AW valid or address changed before handshake");
  end

  w_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
    m_wvalid_o && !m_wready_i |=> m_wvalid_o && $stable(m_wdata_o) && $stable(m_wstrb_o))
  else
  begin
    err_count++;
    $error("W valid or payload changed before handshake");
  end

  // never a read and a write at once
  one_txn: assert property (@(posedge clk) disable iff (!arst_n_i)
    !((m_arvalid_o || m_rready_o) && (m_awvalid_o || m_wvalid_o || m_bready_o)))
  else
  begin
    err_count++;
    $error("read and write transactions in flight together");
  end

  busy_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    (req_valid_i && req_ready_o) || (!req_ready_o && !resp_valid_o) |=> !req_ready_o)
  else
  begin
    err_count++;
    $error("request port reopened before the response");
  end

  reopen: assert property (@(posedge clk) disable iff (!arst_n_i)
    resp_valid_o |-> !req_ready_o ##1 req_ready_o)
  else
  begin
    err_count++;
    $error("request port not reopened right after the response");
  end

  reset_idle: assert property (@(posedge clk)
    !arst_n_i |-> req_ready_o && !resp_valid_o && !m_arvalid_o && !m_rready_o
      && !m_awvalid_o && !m_wvalid_o && !m_bready_o)
  else
  begin
    err_count++;
    $error("control output active during reset");
  end

endmodule

bind lsu_top lsu_assert u_assert (.*);

`default_nettype wire

// File: src/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_top (
  input  wire                   clk,
  input  wire                   arst_n_i,
  // core request and response
  input  wire                   req_valid_i,
  output logic                  req_ready_o,
  input  wire lsu_pkg::lsu_op_e req_op_i,
  input  wire lsu_pkg::addr_t   req_addr_i,
  input  wire lsu_pkg::data_t   req_wdata_i,
  output logic                  resp_valid_o,
  output lsu_pkg::data_t        resp_rdata_o,
  output logic                  resp_err_o,
  // axi4-lite master
  output lsu_pkg::addr_t        m_araddr_o,
  output logic                  m_arvalid_o,
  input  wire                   m_arready_i,
  input  wire lsu_pkg::data_t   m_rdata_i,
  input  wire lsu_pkg::resp_t   m_rresp_i,
  input  wire                   m_rvalid_i,
  output logic                  m_rready_o,
  output lsu_pkg::addr_t        m_awaddr_o,
  output logic                  m_awvalid_o,
  input  wire                   m_awready_i,
  output lsu_pkg::data_t        m_wdata_o,
  output lsu_pkg::strb_t        m_wstrb_o,
  output logic                  m_wvalid_o,
  input  wire                   m_wready_i,
  input  wire lsu_pkg::resp_t   m_bresp_i,
  input  wire                   m_bvalid_i,
  output logic                  m_bready_o
);
  import lsu_pkg::*;

  logic    cmd_valid;
  lsu_op_e cmd_op;
  addr_t   cmd_addr;
  data_t   cmd_wdata;
  strb_t   cmd_strb;
  logic    cmd_load;
  logic    cmd_misaligned;
  logic    rd_start;
  logic    wr_start;
  addr_t   bus_addr;
  data_t   bus_wdata;
  strb_t   bus_strb;
  logic    bus_done;
  data_t   bus_rdata;
  resp_t   bus_resp;
  logic    dc_done;
  data_t   dc_word;
  logic    dc_err;

  lsu_req u_req (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .req_valid_i      (req_valid_i),
    .req_op_i         (req_op_i),
    .req_addr_i       (req_addr_i),
    .req_wdata_i      (req_wdata_i),
    .done_i           (resp_valid_o),
    .req_ready_o      (req_ready_o),
    .cmd_valid_o      (cmd_valid),
    .cmd_op_o         (cmd_op),
    .cmd_addr_o       (cmd_addr),
    .cmd_wdata_o      (cmd_wdata),
    .cmd_strb_o       (cmd_strb),
    .cmd_load_o       (cmd_load),
    .cmd_misaligned_o (cmd_misaligned)
  );

  lsu_dcache u_dcache (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .cmd_valid_i      (cmd_valid),
    .cmd_addr_i       (cmd_addr),
    .cmd_wdata_i      (cmd_wdata),
    .cmd_strb_i       (cmd_strb),
    .cmd_load_i       (cmd_load),
    .cmd_misaligned_i (cmd_misaligned),
    .bus_done_i       (bus_done),
    .bus_rdata_i      (bus_rdata),
    .bus_resp_i       (bus_resp),
    .rd_start_o       (rd_start),
    .wr_start_o       (wr_start),
    .bus_addr_o       (bus_addr),
    .bus_wdata_o      (bus_wdata),
    .bus_strb_o       (bus_strb),
    .done_o           (dc_done),
    .word_o           (dc_word),
    .err_o            (dc_err)
  );

  lsu_axil_master u_axil (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .rd_start_i  (rd_start),
    .wr_start_i  (wr_start),
    .addr_i      (bus_addr),
    .wdata_i     (bus_wdata),
    .strb_i      (bus_strb),
    .m_araddr_o  (m_araddr_o),
    .m_arvalid_o (m_arvalid_o),
    .m_arready_i (m_arready_i),
    .m_rdata_i   (m_rdata_i),
    .m_rresp_i   (m_rresp_i),
    .m_rvalid_i  (m_rvalid_i),
    .m_rready_o  (m_rready_o),
    .m_awaddr_o  (m_awaddr_o),
    .m_awvalid_o (m_awvalid_o),
    .m_awready_i (m_awready_i),
    .m_wdata_o   (m_wdata_o),
    .m_wstrb_o   (m_wstrb_o),
    .m_wvalid_o  (m_wvalid_o),
    .m_wready_i  (m_wready_i),
    .m_bresp_i   (m_bresp_i),
    .m_bvalid_i  (m_bvalid_i),
    .m_bready_o  (m_bready_o),
    .done_o      (bus_done),
    .rdata_o     (bus_rdata),
    .resp_o      (bus_resp)
  );

  // held op and byte offset steer the formatter
  lsu_load_ext u_load_ext (
    .done_i       (dc_done),
    .word_i       (dc_word),
    .err_i        (dc_err),
    .op_i         (cmd_op),
    .offset_i     (cmd_addr[`LSU_OFFSET_W-1:0]),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o),
    .resp_err_o   (resp_err_o)
  );

endmodule

`default_nettype wire

// File: src/lsu_load_ext.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_load_ext (
  input  wire                       done_i,
  input  wire lsu_pkg::data_t       word_i,
  input  wire                       err_i,
  input  wire lsu_pkg::lsu_op_e     op_i,
  input  wire [`LSU_OFFSET_W-1:0]   offset_i,
  output logic                      resp_valid_o,
  output lsu_pkg::data_t            resp_rdata_o,
  output logic                      resp_err_o
);
  import lsu_pkg::*;

  data_t       shifted;
  logic [7:0]  byte_v;
  logic [15:0] half_v;

  // addressed byte down to lane 0
  assign shifted = word_i >> {offset_i, 3'b000};
  assign byte_v  = shifted[7:0];
  assign half_v  = shifted[15:0];

  always_comb
  begin
    resp_rdata_o = '0;
    if (done_i && !err_i)
    begin
      case (op_i)
        LB:      resp_rdata_o = {{(`LSU_DATA_W-8){byte_v[7]}}, byte_v};
        LBU:     resp_rdata_o = data_t'(byte_v);
        LH:      resp_rdata_o = {{(`LSU_DATA_W-16){half_v[15]}}, half_v};
        LHU:     resp_rdata_o = data_t'(half_v);
        LW:      resp_rdata_o = word_i;
        // stores return no data
        default: resp_rdata_o = '0;
      endcase
    end
  end

  assign resp_valid_o = done_i;
  assign resp_err_o   = done_i && err_i;

endmodule

`default_nettype wire

// File: src/lsu_axil_master.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_axil_master (
  input  wire                 clk,
  input  wire                 arst_n_i,
  input  wire                 rd_start_i,
  input  wire                 wr_start_i,
  input  wire lsu_pkg::addr_t addr_i,
  input  wire lsu_pkg::data_t wdata_i,
  input  wire lsu_pkg::strb_t strb_i,
  // read address and data
  output lsu_pkg::addr_t      m_araddr_o,
  output logic                m_arvalid_o,
  input  wire                 m_arready_i,
  input  wire lsu_pkg::data_t m_rdata_i,
  input  wire lsu_pkg::resp_t m_rresp_i,
  input  wire                 m_rvalid_i,
  output logic                m_rready_o,
  // write address, data and response
  output lsu_pkg::addr_t      m_awaddr_o,
  output logic                m_awvalid_o,
  input  wire                 m_awready_i,
  output lsu_pkg::data_t      m_wdata_o,
  output lsu_pkg::strb_t      m_wstrb_o,
  output logic                m_wvalid_o,
  input  wire                 m_wready_i,
  input  wire lsu_pkg::resp_t m_bresp_i,
  input  wire                 m_bvalid_i,
  output logic                m_bready_o,
  output logic                done_o,
  output lsu_pkg::data_t      rdata_o,
  output lsu_pkg::resp_t      resp_o
);
  import lsu_pkg::*;

  addr_t addr_q;
  logic  r_hs;
  logic  b_hs;

  assign m_araddr_o = addr_q;
  assign m_awaddr_o = addr_q;
  assign r_hs       = m_rvalid_i && m_rready_o;
  assign b_hs       = m_bvalid_i && m_bready_o;

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      m_arvalid_o <= 1'b0;
      m_rready_o  <= 1'b0;
      m_awvalid_o <= 1'b0;
      m_wvalid_o  <= 1'b0;
      m_bready_o  <= 1'b0;
      done_o      <= 1'b0;
    end
    else
    begin
      done_o <= r_hs || b_hs;
      if (rd_start_i)
      begin
        m_arvalid_o <= 1'b1;
        m_rready_o  <= 1'b1;
      end
      if (m_arvalid_o && m_arready_i)
        m_arvalid_o <= 1'b0;
      if (r_hs)
        m_rready_o <= 1'b0;
      // aw and w go up together, each drops on its own handshake
      if (wr_start_i)
      begin
        m_awvalid_o <= 1'b1;
        m_wvalid_o  <= 1'b1;
        m_bready_o  <= 1'b1;
      end
      if (m_awvalid_o && m_awready_i)
        m_awvalid_o <= 1'b0;
      if (m_wvalid_o && m_wready_i)
        m_wvalid_o <= 1'b0;
      if (b_hs)
        m_bready_o <= 1'b0;
    end
  end

  // payload held from start to the end of the transaction
  always_ff @(posedge clk)
  begin
    if (rd_start_i || wr_start_i)
    begin
      addr_q    <= addr_i;
      m_wdata_o <= wdata_i;
      m_wstrb_o <= strb_i;
    end
    if (r_hs)
    begin
      rdata_o <= m_rdata_i;
      resp_o  <= m_rresp_i;
    end
    else if (b_hs)
    begin
      rdata_o <= '0;
      resp_o  <= m_bresp_i;
    end
  end

endmodule

`default_nettype wire

// File: src/lsu_dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_dcache (
  input  wire                 clk,
  input  wire                 arst_n_i,
  input  wire                 cmd_valid_i,
  input  wire lsu_pkg::addr_t cmd_addr_i,
  input  wire lsu_pkg::data_t cmd_wdata_i,
  input  wire lsu_pkg::strb_t cmd_strb_i,
  input  wire                 cmd_load_i,
  input  wire                 cmd_misaligned_i,
  input  wire                 bus_done_i,
  input  wire lsu_pkg::data_t bus_rdata_i,
  input  wire lsu_pkg::resp_t bus_resp_i,
  output logic                rd_start_o,
  output logic                wr_start_o,
  output lsu_pkg::addr_t      bus_addr_o,
  output lsu_pkg::data_t      bus_wdata_o,
  output lsu_pkg::strb_t      bus_strb_o,
  output logic                done_o,
  output lsu_pkg::data_t      word_o,
  output logic                err_o
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {IDLE, READ, WRITE} state_e;

  state_e                    state_q;
  state_e                    state_d;
  data_t                     data_mem [`LSU_L1D_LINES];
  tag_t                      tag_mem [`LSU_L1D_LINES];
  logic [`LSU_L1D_LINES-1:0] valid_q;
  index_t                    idx;
  tag_t                      tag;
  logic                      hit;
  logic                      fill;
  logic                      inval;

  assign idx = cmd_addr_i[`LSU_OFFSET_W +: `LSU_L1D_IDX_W];
  assign tag = cmd_addr_i[`LSU_ADDR_W-1:`LSU_OFFSET_W+`LSU_L1D_IDX_W];
  assign hit = valid_q[idx] && (tag_mem[idx] == tag);

  // bus always sees the aligned word
  assign bus_addr_o  = {cmd_addr_i[`LSU_ADDR_W-1:`LSU_OFFSET_W], {`LSU_OFFSET_W{1'b0}}};
  assign bus_wdata_o = cmd_wdata_i;
  assign bus_strb_o  = cmd_strb_i;

  always_comb
  begin
    state_d    = state_q;
    rd_start_o = 1'b0;
    wr_start_o = 1'b0;
    done_o     = 1'b0;
    word_o     = '0;
    err_o      = 1'b0;
    fill       = 1'b0;
    inval      = 1'b0;
    case (state_q)
      IDLE:
        if (cmd_valid_i)
        begin
          if (cmd_misaligned_i)
          begin
            done_o = 1'b1;
            err_o  = 1'b1;
          end
          else if (cmd_load_i && hit)
          begin
            done_o = 1'b1;
            word_o = data_mem[idx];
          end
          else if (cmd_load_i)
          begin
            rd_start_o = 1'b1;
            state_d    = READ;
          end
          else
          begin
            // write-through, a stored-to line is dropped
            wr_start_o = 1'b1;
            inval      = hit;
            state_d    = WRITE;
          end
        end
      READ:
        if (bus_done_i)
        begin
          done_o  = 1'b1;
          err_o   = (bus_resp_i != `LSU_RESP_OKAY);
          word_o  = err_o ? '0 : bus_rdata_i;
          fill    = ~err_o;
          state_d = IDLE;
        end
      WRITE:
        if (bus_done_i)
        begin
          done_o  = 1'b1;
          err_o   = (bus_resp_i != `LSU_RESP_OKAY);
          state_d = IDLE;
        end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (fill)
    begin
      data_mem[idx] <= bus_rdata_i;
      tag_mem[idx]  <= tag;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q <= IDLE;
      valid_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (fill)
        valid_q[idx] <= 1'b1;
      else if (inval)
        valid_q[idx] <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/lsu_req.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_req (
  input  wire                   clk,
  input  wire                   arst_n_i,
  input  wire                   req_valid_i,
  input  wire lsu_pkg::lsu_op_e req_op_i,
  input  wire lsu_pkg::addr_t   req_addr_i,
  input  wire lsu_pkg::data_t   req_wdata_i,
  input  wire                   done_i,
  output logic                  req_ready_o,
  output logic                  cmd_valid_o,
  output lsu_pkg::lsu_op_e      cmd_op_o,
  output lsu_pkg::addr_t        cmd_addr_o,
  output lsu_pkg::data_t        cmd_wdata_o,
  output lsu_pkg::strb_t        cmd_strb_o,
  output logic                  cmd_load_o,
  output logic                  cmd_misaligned_o
);
  import lsu_pkg::*;

  logic                     busy_q;
  logic                     accept;
  data_t                    wdata_q;
  strb_t                    base_strb;
  logic [`LSU_OFFSET_W-1:0] offset;

  assign req_ready_o = ~busy_q;
  assign accept      = req_valid_i && req_ready_o;
  assign offset      = cmd_addr_o[`LSU_OFFSET_W-1:0];

  // busy from accept until the response pulse
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_q      <= 1'b0;
      cmd_valid_o <= 1'b0;
    end
    else
    begin
      cmd_valid_o <= accept;
      if (accept)
        busy_q <= 1'b1;
      else if (done_i)
        busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_op_o   <= req_op_i;
      cmd_addr_o <= req_addr_i;
      wdata_q    <= req_wdata_i;
    end
  end

  // strobe width and alignment by op
  always_comb
  begin
    base_strb        = '0;
    cmd_misaligned_o = 1'b0;
    case (cmd_op_o)
      LH, LHU: cmd_misaligned_o = offset[0];
      LW:      cmd_misaligned_o = |offset;
      SB:      base_strb = strb_t'(1'b1);
      SH:
      begin
        base_strb        = strb_t'(2'b11);
        cmd_misaligned_o = offset[0];
      end
      SW:
      begin
        base_strb        = '1;
        cmd_misaligned_o = |offset;
      end
      default: base_strb = '0;
    endcase
  end

  assign cmd_load_o  = cmd_op_o inside {LB, LBU, LH, LHU, LW};

  // move lanes up to the addressed byte
  assign cmd_strb_o  = base_strb << offset;
  assign cmd_wdata_o = wdata_q << {offset, 3'b000};

endmodule

`default_nettype wire

// File: src/lsu_pkg.sv
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

  // byte address and data word
  typedef logic [`LSU_ADDR_W-1:0] addr_t;
  typedef logic [`LSU_DATA_W-1:0] data_t;

  // one strobe bit per byte lane
  typedef logic [`LSU_DATA_W/8-1:0] strb_t;

  // cache address split
  typedef logic [`LSU_L1D_IDX_W-1:0] index_t;
  typedef logic [`LSU_ADDR_W-`LSU_L1D_IDX_W-`LSU_OFFSET_W-1:0] tag_t;

  // axi response code
  typedef logic [1:0] resp_t;

  // memory operation from execute stage
  typedef enum logic [2:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

endpackage

`default_nettype wire

// File: src/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// datapath widths
`define LSU_ADDR_W      32
`define LSU_DATA_W      32

// direct-mapped l1d geometry, one word per line
`define LSU_L1D_IDX_W   6
`define LSU_L1D_LINES   64
`define LSU_OFFSET_W    2

// axi response codes
`define LSU_RESP_OKAY   2'b00
`define LSU_RESP_SLVERR 2'b10

`endif
